//--- eth_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
	input  wire                  i_sys_clk,
	input  wire                  i_reset_n,
	input  wire                  i_init,    // wins over i_en
	input  wire                  i_en,
	input  wire eth_frame_pkg::byte_t i_data,
	output logic [31:0]          o_crc
);

	logic [31:0] crc_next;

	// one byte per cycle, bit 0 first
	always_comb begin
		crc_next = o_crc;
		for (int b = 0; b < 8; b++) begin
			if (crc_next[0] ^ i_data[b]) begin
				crc_next = (crc_next >> 1) ^ eth_frame_pkg::CRC_POLY;
			end else begin
				crc_next = crc_next >> 1;
			end
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (!i_reset_n) begin
			o_crc <= eth_frame_pkg::CRC_INIT;
		end else if (i_init) begin
			o_crc <= eth_frame_pkg::CRC_INIT;
		end else if (i_en) begin
			o_crc <= crc_next;   // no final xor here, tx inverts on output
		end
	end

endmodule

`default_nettype wire

//--- eth_ctrl_pkg.sv
`default_nettype none

package eth_ctrl_pkg;

	typedef logic [15:0] len_t;    // byte counts and field indices
	typedef logic [31:0] word_t;   // user data word, big endian

	// transmit fields, in wire order
	typedef enum logic [3:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_SFD,
		TX_ETH_HDR,
		TX_IP_HDR,
		TX_UDP_HDR,
		TX_PAYLOAD,
		TX_PAD,       // skipped for payloads of 18 bytes and up
		TX_FCS,
		TX_GAP        // inter-frame gap, starts are ignored here
	} tx_state_t;

	// receive parser states
	typedef enum logic [2:0] {
		RX_HUNT,      // waiting for sfd
		RX_ETH_HDR,
		RX_IP_HDR,
		RX_UDP_HDR,
		RX_PAYLOAD,
		RX_TAIL,      // pad and fcs
		RX_DROP       // filtered, wait for end of frame
	} rx_state_t;

	localparam int IFG_LEN     = 12;
	localparam int MAX_PAYLOAD = 1472;   // 1500 byte mtu less ip and udp headers

endpackage

`default_nettype wire

//--- eth_field_counter.sv
`timescale 1ns/1ps
`default_nettype none

module eth_field_counter (
	input  wire                      i_sys_clk,
	input  wire                      i_reset_n,
	input  wire                      i_load,    // first byte of a new field next cycle
	input  wire eth_ctrl_pkg::len_t  i_len,     // field length, at least 1
	output eth_ctrl_pkg::len_t       o_index,
	output logic                     o_last
);

	eth_ctrl_pkg::len_t last_idx;   // index of the final byte

	// ########################################
	// one counter times every field and the gap
	always_ff @(posedge i_sys_clk) begin
		if (!i_reset_n) begin
			o_index  <= '0;
			last_idx <= '0;
		end else if (i_load) begin
			o_index  <= '0;
			last_idx <= i_len - 1'b1;
		end else begin
			o_index <= o_index + 1'b1;   // free runs in idle, nobody looks
		end
	end

	assign o_last = (o_index == last_idx);

endmodule

`default_nettype wire

//--- eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

	// ########################################
	// field types on the wire
	typedef logic [7:0]  byte_t;   // one gmii byte
	typedef logic [47:0] mac_t;    // msb goes out first
	typedef logic [31:0] ip_t;

	// ########################################
	// frame layout, all lengths in bytes
	localparam int PREAMBLE_LEN = 7;       // 0x55 bytes ahead of the sfd
	localparam int ETH_HDR_LEN  = 14;      // dest mac, src mac, ethertype
	localparam int IP_HDR_LEN   = 20;      // no options
	localparam int UDP_HDR_LEN  = 8;
	localparam int MIN_PAYLOAD  = 18;      // udp payload that fills a 46 byte ip packet
	localparam int FCS_LEN      = 4;

	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE      = 8'hd5;

	// header constants
	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam byte_t       IP_VER_IHL     = 8'h45;     // v4, 5 words
	localparam logic [15:0] IP_FLAGS       = 16'h4000;  // dont fragment
	localparam byte_t       IP_TTL         = 8'h40;
	localparam byte_t       IP_PROTO_UDP   = 8'd17;
	localparam logic [15:0] UDP_PORT       = 16'h1234;  // same port both ways

	// ########################################
	// reflected crc-32, lsb first on the wire
	localparam logic [31:0] CRC_INIT    = 32'hffff_ffff;
	localparam logic [31:0] CRC_POLY    = 32'hedb8_8320;
	localparam logic [31:0] CRC_RESIDUE = 32'hdebb_20e3;  // register value after a good fcs

endpackage

`default_nettype wire

//--- eth_rx_parser.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_parser (
	input  wire                       i_sys_clk,
	input  wire                       i_reset_n,
	input  wire                       i_gmii_rxen,
	input  wire eth_frame_pkg::byte_t i_gmii_rxdat,
	input  wire eth_frame_pkg::mac_t  i_local_mac,
	input  wire eth_frame_pkg::ip_t   i_local_ip,
	output logic                      o_rxd_wr_en,
	output eth_ctrl_pkg::word_t       o_rxd_wr_data,
	output eth_ctrl_pkg::len_t        o_rxd_wr_byte_num,
	output logic                      o_rxd_pkt_done,
	output logic                      o_rxd_pkt_err
);

	eth_ctrl_pkg::rx_state_t state;
	eth_ctrl_pkg::len_t      idx;        // byte index within the field
	eth_frame_pkg::byte_t    len_hi;     // udp length, upper byte
	eth_ctrl_pkg::word_t     next_word;
	logic [31:0]             crc;
	logic                    hdr_ok;
	logic                    crc_en;
	logic                    pay_last;

	assign crc_en = i_gmii_rxen && (state != eth_ctrl_pkg::RX_HUNT)
		&& (state != eth_ctrl_pkg::RX_DROP);

	eth_crc32 u_crc (
		.i_sys_clk (i_sys_clk),
		.i_reset_n (i_reset_n),
		.i_init    (state == eth_ctrl_pkg::RX_HUNT),
		.i_en      (crc_en),
		.i_data    (i_gmii_rxdat),
		.o_crc     (crc)
	);

	// ########################################
	// header filter, byte by byte
	always_comb begin
		hdr_ok = 1'b1;
		if (state == eth_ctrl_pkg::RX_ETH_HDR) begin
			if (idx < 16'd6) hdr_ok = (i_gmii_rxdat == i_local_mac[8 * (5 - int'(idx)) +: 8]);
			if (idx == 16'd12) hdr_ok = (i_gmii_rxdat == eth_frame_pkg::ETHERTYPE_IPV4[15:8]);
			if (idx == 16'd13) hdr_ok = (i_gmii_rxdat == eth_frame_pkg::ETHERTYPE_IPV4[7:0]);
		end else if (state == eth_ctrl_pkg::RX_IP_HDR) begin
			if (idx == 16'd0) hdr_ok = (i_gmii_rxdat == eth_frame_pkg::IP_VER_IHL);   // no options
			if (idx == 16'd9) hdr_ok = (i_gmii_rxdat == eth_frame_pkg::IP_PROTO_UDP);
			if (idx >= 16'd16) hdr_ok = (i_gmii_rxdat == i_local_ip[8 * (19 - int'(idx)) +: 8]);
		end
	end

	// big endian packing, a new word starts zero filled
	assign next_word = ((idx[1:0] == 2'd0) ? 32'h0 : o_rxd_wr_data)
		| ({i_gmii_rxdat, 24'h0} >> {idx[1:0], 3'b000});
	assign pay_last = (idx == o_rxd_wr_byte_num - 1'b1);

	always_ff @(posedge i_sys_clk) begin
		if (!i_reset_n) begin
			state          <= eth_ctrl_pkg::RX_HUNT;
			idx            <= '0;
			o_rxd_wr_en    <= 1'b0;
			o_rxd_pkt_done <= 1'b0;
			o_rxd_pkt_err  <= 1'b0;
		end else begin
			o_rxd_wr_en    <= 1'b0;
			o_rxd_pkt_done <= 1'b0;
			o_rxd_pkt_err  <= 1'b0;
			idx            <= idx + 1'b1;
			if (!i_gmii_rxen) begin
				// end of frame, only filtered frames report
				if (state == eth_ctrl_pkg::RX_PAYLOAD || state == eth_ctrl_pkg::RX_TAIL) begin
					o_rxd_pkt_done <= (crc == eth_frame_pkg::CRC_RESIDUE);
					o_rxd_pkt_err  <= (crc != eth_frame_pkg::CRC_RESIDUE);
				end
				state <= eth_ctrl_pkg::RX_HUNT;
			end else begin
				case (state)
					eth_ctrl_pkg::RX_HUNT: begin
						if (i_gmii_rxdat == eth_frame_pkg::SFD_BYTE) begin
							state <= eth_ctrl_pkg::RX_ETH_HDR;
							idx   <= '0;
						end
					end
					eth_ctrl_pkg::RX_ETH_HDR: begin
						if (!hdr_ok) begin
							state <= eth_ctrl_pkg::RX_DROP;
						end else if (idx == 16'(eth_frame_pkg::ETH_HDR_LEN - 1)) begin
							state <= eth_ctrl_pkg::RX_IP_HDR;
							idx   <= '0;
						end
					end
					eth_ctrl_pkg::RX_IP_HDR: begin
						if (!hdr_ok) begin
							state <= eth_ctrl_pkg::RX_DROP;
						end else if (idx == 16'(eth_frame_pkg::IP_HDR_LEN - 1)) begin
							state <= eth_ctrl_pkg::RX_UDP_HDR;
							idx   <= '0;
						end
					end
					eth_ctrl_pkg::RX_UDP_HDR: begin
						if (idx == 16'(eth_frame_pkg::UDP_HDR_LEN - 1)) begin
							state <= (o_rxd_wr_byte_num == '0) ? eth_ctrl_pkg::RX_TAIL
								: eth_ctrl_pkg::RX_PAYLOAD;
							idx   <= '0;
						end
					end
					eth_ctrl_pkg::RX_PAYLOAD: begin
						if (idx[1:0] == 2'd3 || pay_last) o_rxd_wr_en <= 1'b1;   // full or final word
						if (pay_last) state <= eth_ctrl_pkg::RX_TAIL;   // rest is pad and fcs
					end
					default: ;   // tail, drop: wait for rxen to fall
				endcase
			end
		end
	end

	// udp length and payload word, no reset needed
	always_ff @(posedge i_sys_clk) begin
		if (state == eth_ctrl_pkg::RX_UDP_HDR && idx == 16'd4) len_hi <= i_gmii_rxdat;
		if (state == eth_ctrl_pkg::RX_UDP_HDR && idx == 16'd5) begin
			o_rxd_wr_byte_num <= {len_hi, i_gmii_rxdat} - 16'(eth_frame_pkg::UDP_HDR_LEN);
		end
		if (state == eth_ctrl_pkg::RX_PAYLOAD) o_rxd_wr_data <= next_word;
	end

endmodule

`default_nettype wire

//--- eth_top.f
eth_frame_pkg.sv
eth_ctrl_pkg.sv
eth_crc32.sv
eth_field_counter.sv
eth_tx_fsm.sv
eth_tx_datapath.sv
eth_rx_parser.sv
eth_top.sv
tb_eth_top.sv

//--- eth_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_top (
	input  wire                       i_sys_clk,
	input  wire                       i_reset_n,
	// gmii
	input  wire                       i_gmii_rxen,
	input  wire eth_frame_pkg::byte_t i_gmii_rxdat,
	output logic                      o_gmii_txen,
	output eth_frame_pkg::byte_t      o_gmii_txdat,
	// addresses, held static
	input  wire eth_frame_pkg::mac_t  i_local_mac,
	input  wire eth_frame_pkg::ip_t   i_local_ip,
	input  wire eth_frame_pkg::mac_t  i_dest_mac,
	input  wire eth_frame_pkg::ip_t   i_dest_ip,
	// user transmit side
	input  wire                       i_tx_start_en,
	input  wire eth_ctrl_pkg::len_t   i_tx_byte_num,
	input  wire eth_ctrl_pkg::word_t  i_tx_data,
	output logic                      o_tx_data_req,
	output logic                      o_tx_data_done,
	// user receive side
	output logic                      o_rxd_wr_en,
	output eth_ctrl_pkg::word_t       o_rxd_wr_data,
	output eth_ctrl_pkg::len_t        o_rxd_wr_byte_num,
	output logic                      o_rxd_pkt_done,
	output logic                      o_rxd_pkt_err
);

	eth_ctrl_pkg::tx_state_t tx_state;
	logic                    field_first;
	logic                    field_last;
	logic                    cnt_load;
	eth_ctrl_pkg::len_t      cnt_len;
	eth_ctrl_pkg::len_t      field_index;
	eth_ctrl_pkg::len_t      pay_len;

	// ########################################
	// transmit path
	eth_tx_fsm u_tx_fsm (
		.i_sys_clk      (i_sys_clk),
		.i_reset_n      (i_reset_n),
		.i_tx_start_en  (i_tx_start_en),
		.i_tx_byte_num  (i_tx_byte_num),
		.i_field_last   (field_last),
		.i_field_index  (field_index),
		.o_state        (tx_state),
		.o_field_first  (field_first),
		.o_cnt_load     (cnt_load),
		.o_cnt_len      (cnt_len),
		.o_pay_len      (pay_len),
		.o_tx_data_req  (o_tx_data_req),
		.o_tx_data_done (o_tx_data_done)
	);

	eth_field_counter u_field_cnt (
		.i_sys_clk (i_sys_clk),
		.i_reset_n (i_reset_n),
		.i_load    (cnt_load),
		.i_len     (cnt_len),
		.o_index   (field_index),
		.o_last    (field_last)
	);

	eth_tx_datapath u_tx_dp (
		.i_sys_clk     (i_sys_clk),
		.i_reset_n     (i_reset_n),
		.i_state       (tx_state),
		.i_field_first (field_first),
		.i_field_index (field_index),
		.i_pay_len     (pay_len),
		.i_tx_data     (i_tx_data),
		.i_local_mac   (i_local_mac),
		.i_dest_mac    (i_dest_mac),
		.i_local_ip    (i_local_ip),
		.i_dest_ip     (i_dest_ip),
		.o_gmii_txen   (o_gmii_txen),
		.o_gmii_txdat  (o_gmii_txdat)
	);

	// ########################################
	// receive path
	eth_rx_parser u_rx (
		.i_sys_clk         (i_sys_clk),
		.i_reset_n         (i_reset_n),
		.i_gmii_rxen       (i_gmii_rxen),
		.i_gmii_rxdat      (i_gmii_rxdat),
		.i_local_mac       (i_local_mac),
		.i_local_ip        (i_local_ip),
		.o_rxd_wr_en       (o_rxd_wr_en),
		.o_rxd_wr_data     (o_rxd_wr_data),
		.o_rxd_wr_byte_num (o_rxd_wr_byte_num),
		.o_rxd_pkt_done    (o_rxd_pkt_done),
		.o_rxd_pkt_err     (o_rxd_pkt_err)
	);

endmodule

`default_nettype wire

//--- eth_tx_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_datapath (
	input  wire                          i_sys_clk,
	input  wire                          i_reset_n,
	input  wire eth_ctrl_pkg::tx_state_t i_state,
	input  wire                          i_field_first,
	input  wire eth_ctrl_pkg::len_t      i_field_index,
	input  wire eth_ctrl_pkg::len_t      i_pay_len,
	input  wire eth_ctrl_pkg::word_t     i_tx_data,
	input  wire eth_frame_pkg::mac_t     i_local_mac,
	input  wire eth_frame_pkg::mac_t     i_dest_mac,
	input  wire eth_frame_pkg::ip_t      i_local_ip,
	input  wire eth_frame_pkg::ip_t      i_dest_ip,
	output logic                         o_gmii_txen,
	output eth_frame_pkg::byte_t         o_gmii_txdat
);

	eth_ctrl_pkg::len_t   ip_len;      // ip total length
	eth_ctrl_pkg::len_t   udp_len;
	logic [31:0]          csum_sum;
	logic [31:0]          csum_fold;
	logic [15:0]          ip_csum;
	logic [111:0]         eth_hdr;
	logic [159:0]         ip_hdr;
	logic [63:0]          udp_hdr;
	eth_ctrl_pkg::word_t  pay_sr;      // current payload word, msb byte next
	eth_frame_pkg::byte_t tx_byte;
	logic [31:0]          crc;
	logic                 crc_en;
	logic                 load_word;

	assign udp_len = i_pay_len + 16'(eth_frame_pkg::UDP_HDR_LEN);
	assign ip_len  = udp_len + 16'(eth_frame_pkg::IP_HDR_LEN);

	// ########################################
	// ip header checksum, ones complement
	assign csum_sum = {eth_frame_pkg::IP_VER_IHL, 8'h00} + ip_len + eth_frame_pkg::IP_FLAGS
		+ {eth_frame_pkg::IP_TTL, eth_frame_pkg::IP_PROTO_UDP}
		+ i_local_ip[31:16] + i_local_ip[15:0] + i_dest_ip[31:16] + i_dest_ip[15:0];
	assign csum_fold = csum_sum[15:0] + csum_sum[31:16];   // id field is zero

	always_ff @(posedge i_sys_clk) begin
		if (i_state == eth_ctrl_pkg::TX_IP_HDR && i_field_first) begin
			ip_csum <= ~(csum_fold[15:0] + csum_fold[31:16]);   // needed from byte 10
		end
	end

	assign eth_hdr = {i_dest_mac, i_local_mac, eth_frame_pkg::ETHERTYPE_IPV4};
	assign ip_hdr  = {eth_frame_pkg::IP_VER_IHL, 8'h00, ip_len, 16'h0000,
		eth_frame_pkg::IP_FLAGS, eth_frame_pkg::IP_TTL, eth_frame_pkg::IP_PROTO_UDP,
		ip_csum, i_local_ip, i_dest_ip};
	assign udp_hdr = {eth_frame_pkg::UDP_PORT, eth_frame_pkg::UDP_PORT, udp_len, 16'h0000};

	// word arrives on the last udp header byte and every fourth payload byte
	assign load_word =
		((i_state == eth_ctrl_pkg::TX_UDP_HDR)
			&& (i_field_index == 16'(eth_frame_pkg::UDP_HDR_LEN - 1)))
		|| ((i_state == eth_ctrl_pkg::TX_PAYLOAD) && (i_field_index[1:0] == 2'd3));

	always_ff @(posedge i_sys_clk) begin
		if (load_word) begin
			pay_sr <= i_tx_data;
		end else if (i_state == eth_ctrl_pkg::TX_PAYLOAD) begin
			pay_sr <= {pay_sr[23:0], 8'h00};
		end
	end

	// ########################################
	// byte select
	always_comb begin
		case (i_state)
			eth_ctrl_pkg::TX_PREAMBLE: tx_byte = eth_frame_pkg::PREAMBLE_BYTE;
			eth_ctrl_pkg::TX_SFD:      tx_byte = eth_frame_pkg::SFD_BYTE;
			eth_ctrl_pkg::TX_ETH_HDR:  tx_byte = eth_hdr[8 * (13 - int'(i_field_index)) +: 8];
			eth_ctrl_pkg::TX_IP_HDR:   tx_byte = ip_hdr[8 * (19 - int'(i_field_index)) +: 8];
			eth_ctrl_pkg::TX_UDP_HDR:  tx_byte = udp_hdr[8 * (7 - int'(i_field_index)) +: 8];
			eth_ctrl_pkg::TX_PAYLOAD:  tx_byte = pay_sr[31:24];
			eth_ctrl_pkg::TX_FCS:      tx_byte = ~crc[8 * int'(i_field_index[1:0]) +: 8];   // low byte first
			default:                   tx_byte = 8'h00;   // pad, idle, gap
		endcase
	end

	// fcs covers ethernet header through pad
	assign crc_en = i_state inside {eth_ctrl_pkg::TX_ETH_HDR, eth_ctrl_pkg::TX_IP_HDR,
		eth_ctrl_pkg::TX_UDP_HDR, eth_ctrl_pkg::TX_PAYLOAD, eth_ctrl_pkg::TX_PAD};

	eth_crc32 u_crc (
		.i_sys_clk (i_sys_clk),
		.i_reset_n (i_reset_n),
		.i_init    (i_state == eth_ctrl_pkg::TX_SFD),
		.i_en      (crc_en),
		.i_data    (tx_byte),
		.o_crc     (crc)
	);

	always_ff @(posedge i_sys_clk) begin
		if (!i_reset_n) begin
			o_gmii_txen <= 1'b0;
		end else begin
			o_gmii_txen <= (i_state != eth_ctrl_pkg::TX_IDLE) && (i_state != eth_ctrl_pkg::TX_GAP);
		end
		o_gmii_txdat <= tx_byte;
	end

endmodule

`default_nettype wire

//--- eth_tx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_fsm (
	input  wire                         i_sys_clk,
	input  wire                         i_reset_n,
	input  wire                         i_tx_start_en,
	input  wire eth_ctrl_pkg::len_t     i_tx_byte_num,
	input  wire                         i_field_last,
	input  wire eth_ctrl_pkg::len_t     i_field_index,
	output eth_ctrl_pkg::tx_state_t     o_state,
	output logic                        o_field_first,
	output logic                        o_cnt_load,
	output eth_ctrl_pkg::len_t          o_cnt_len,
	output eth_ctrl_pkg::len_t          o_pay_len,
	output logic                        o_tx_data_req,
	output logic                        o_tx_data_done
);

	eth_ctrl_pkg::tx_state_t state_next;   // field after the current one
	logic start_ok;
	logic req_next;

	// zero and oversize lengths are not a frame
	assign start_ok = i_tx_start_en && (i_tx_byte_num != '0)
		&& (i_tx_byte_num <= 16'(eth_ctrl_pkg::MAX_PAYLOAD));

	// ########################################
	// field order and lengths
	always_comb begin
		state_next = eth_ctrl_pkg::TX_IDLE;
		o_cnt_len  = '0;
		case (o_state)
			eth_ctrl_pkg::TX_IDLE: begin
				state_next = eth_ctrl_pkg::TX_PREAMBLE;
				o_cnt_len  = 16'(eth_frame_pkg::PREAMBLE_LEN);
			end
			eth_ctrl_pkg::TX_PREAMBLE: begin
				state_next = eth_ctrl_pkg::TX_SFD;
				o_cnt_len  = 16'd1;   // single sfd byte
			end
			eth_ctrl_pkg::TX_SFD: begin
				state_next = eth_ctrl_pkg::TX_ETH_HDR;
				o_cnt_len  = 16'(eth_frame_pkg::ETH_HDR_LEN);
			end
			eth_ctrl_pkg::TX_ETH_HDR: begin
				state_next = eth_ctrl_pkg::TX_IP_HDR;
				o_cnt_len  = 16'(eth_frame_pkg::IP_HDR_LEN);
			end
			eth_ctrl_pkg::TX_IP_HDR: begin
				state_next = eth_ctrl_pkg::TX_UDP_HDR;
				o_cnt_len  = 16'(eth_frame_pkg::UDP_HDR_LEN);
			end
			eth_ctrl_pkg::TX_UDP_HDR: begin
				state_next = eth_ctrl_pkg::TX_PAYLOAD;
				o_cnt_len  = o_pay_len;
			end
			eth_ctrl_pkg::TX_PAYLOAD: begin
				if (o_pay_len < 16'(eth_frame_pkg::MIN_PAYLOAD)) begin
					state_next = eth_ctrl_pkg::TX_PAD;   // short frame, fill to 46
					o_cnt_len  = 16'(eth_frame_pkg::MIN_PAYLOAD) - o_pay_len;
				end else begin
					state_next = eth_ctrl_pkg::TX_FCS;
					o_cnt_len  = 16'(eth_frame_pkg::FCS_LEN);
				end
			end
			eth_ctrl_pkg::TX_PAD: begin
				state_next = eth_ctrl_pkg::TX_FCS;
				o_cnt_len  = 16'(eth_frame_pkg::FCS_LEN);
			end
			eth_ctrl_pkg::TX_FCS: begin
				state_next = eth_ctrl_pkg::TX_GAP;
				o_cnt_len  = 16'(eth_ctrl_pkg::IFG_LEN);
			end
			default: state_next = eth_ctrl_pkg::TX_IDLE;   // end of gap
		endcase
	end

	assign o_cnt_load = (o_state == eth_ctrl_pkg::TX_IDLE) ? start_ok : i_field_last;

	// word fetch lands 2 cycles later, one byte before it is shifted out
	assign req_next =
		((o_state == eth_ctrl_pkg::TX_UDP_HDR)
			&& (i_field_index == 16'(eth_frame_pkg::UDP_HDR_LEN - 3)))
		|| ((o_state == eth_ctrl_pkg::TX_PAYLOAD) && (i_field_index[1:0] == 2'd1)
			&& (i_field_index + 16'd3 < o_pay_len));   // another word still to go

	always_ff @(posedge i_sys_clk) begin
		if (!i_reset_n) begin
			o_state        <= eth_ctrl_pkg::TX_IDLE;
			o_field_first  <= 1'b0;
			o_pay_len      <= '0;
			o_tx_data_req  <= 1'b0;
			o_tx_data_done <= 1'b0;
		end else begin
			if (o_cnt_load) o_state <= state_next;
			if (o_state == eth_ctrl_pkg::TX_IDLE && start_ok) o_pay_len <= i_tx_byte_num;
			o_field_first  <= o_cnt_load;
			o_tx_data_req  <= req_next;
			// txen falls as the gap starts, done follows a cycle later
			o_tx_data_done <= (o_state == eth_ctrl_pkg::TX_GAP) && (i_field_index == 16'd1);
		end
	end

endmodule

`default_nettype wire

//--- tb_eth_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_top;

	localparam int NUM_FRAMES   = 10;
	localparam int DOUBLE_FRAME = 9;    // second start lands mid frame
	localparam int KIND_CLEAN   = 0;
	localparam int KIND_FLIP    = 1;    // one wire byte inverted in the loopback
	localparam int KIND_BAD_MAC = 2;    // first dest mac byte replaced

	localparam eth_frame_pkg::mac_t LOCAL_MAC = 48'h02_00_5e_10_20_30;
	localparam eth_frame_pkg::ip_t  LOCAL_IP  = 32'hc0a8_0102;

	logic                 sys_clk;
	logic                 reset_n;
	logic                 tx_start;
	eth_ctrl_pkg::len_t   tx_num;
	eth_ctrl_pkg::word_t  tx_data = '0;
	logic                 rxen = 1'b0;
	eth_frame_pkg::byte_t rxdat = '0;
	logic                 txen;
	eth_frame_pkg::byte_t txdat;
	logic                 data_req;
	logic                 data_done;
	logic                 wr_en;
	eth_ctrl_pkg::word_t  wr_data;
	eth_ctrl_pkg::len_t   wr_byte_num;
	logic                 pkt_done;
	logic                 pkt_err;

	logic [31:0] lfsr_state = 32'hc66b_8eac;
	int plan_len [NUM_FRAMES];
	int plan_kind [NUM_FRAMES];
	int plan_flip [NUM_FRAMES];   // wire byte to invert, -1 for none
	int cur_len;
	int frame_kind;
	int flip_pos;
	int wr_base;
	int start_cyc;
	int frames_started;
	int cyc = 0;
	int cyc_limit = 0;
	eth_ctrl_pkg::word_t word_seed;
	eth_ctrl_pkg::word_t word_ctr;    // next word handed out on a request
	eth_ctrl_pkg::word_t frame_base;  // first word of the current frame
	int   tx_pos;                     // byte index within the txen burst
	int   burst_total;
	int   req_count;
	int   tx_done_total;
	logic prev_txen;
	logic fell_last;
	int   wr_total;
	int   ok_total;
	int   err_total;

	eth_top i_dut (
		.i_sys_clk         (sys_clk),
		.i_reset_n         (reset_n),
		.i_gmii_rxen       (rxen),
		.i_gmii_rxdat      (rxdat),
		.o_gmii_txen       (txen),
		.o_gmii_txdat      (txdat),
		.i_local_mac       (LOCAL_MAC),
		.i_local_ip        (LOCAL_IP),
		.i_dest_mac        (LOCAL_MAC),   // talks to itself
		.i_dest_ip         (LOCAL_IP),
		.i_tx_start_en     (tx_start),
		.i_tx_byte_num     (tx_num),
		.i_tx_data         (tx_data),
		.o_tx_data_req     (data_req),
		.o_tx_data_done    (data_done),
		.o_rxd_wr_en       (wr_en),
		.o_rxd_wr_data     (wr_data),
		.o_rxd_wr_byte_num (wr_byte_num),
		.o_rxd_pkt_done    (pkt_done),
		.o_rxd_pkt_err     (pkt_err)
	);

	// ########################################
	// helpers
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
	endfunction

	task automatic draw_bits(input int nbits, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// preamble and sfd, 42 header bytes, padded payload, fcs
	function automatic int wire_len(input int n);
		return 8 + 42 + ((n < 18) ? 18 : n) + 4;
	endfunction

	// eth, ip and udp header byte pos after the sfd, both addresses are our own
	function automatic eth_frame_pkg::byte_t header_byte(input int n, input int pos);
		logic [335:0] hdr;
		logic [31:0]  sum;
		logic [15:0]  csum;
		sum = 32'h4500 + 32'(n + 28) + 32'h4000 + 32'h4011
			+ LOCAL_IP[31:16] + LOCAL_IP[15:0] + LOCAL_IP[31:16] + LOCAL_IP[15:0];
		sum  = sum[15:0] + sum[31:16];   // end around carry, twice
		sum  = sum[15:0] + sum[31:16];
		csum = ~sum[15:0];
		hdr = {LOCAL_MAC, LOCAL_MAC, 16'h0800,
			16'h4500, 16'(n + 28), 16'h0000, 16'h4000, 16'h4011, csum, LOCAL_IP, LOCAL_IP,
			16'h1234, 16'h1234, 16'(n + 8), 16'h0000};
		return hdr[8 * (41 - pos) +: 8];
	endfunction

	function automatic eth_ctrl_pkg::word_t expected_word(input eth_ctrl_pkg::word_t base,
		input int idx, input int n);
		eth_ctrl_pkg::word_t w;
		int rem;
		w   = base + idx;
		rem = n - 4 * idx;
		if (rem < 4) w = w & ~(32'hffff_ffff >> (8 * rem));   // low bytes past n are zero
		return w;
	endfunction

	task automatic abort_run();
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		abort_run();
	endtask

	task automatic report_failure(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		abort_run();
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
		if (cyc_limit > 0 && cyc >= cyc_limit) report_failure("timeout, frames did not finish");
	end

	// ########################################
	// word feed, loopback and tx checks
	always @(posedge sys_clk) begin
		if (!reset_n) begin
			tx_pos        <= 0;
			burst_total   <= 0;
			req_count     <= 0;
			tx_done_total <= 0;
			prev_txen     <= 1'b0;
			fell_last     <= 1'b0;
			word_ctr      <= word_seed;
		end else begin
			if (data_req) begin
				tx_data  <= word_ctr;   // sampled by the dut one cycle on
				word_ctr <= word_ctr + 1'b1;
			end
			rxen  <= txen;
			rxdat <= txdat;
			if (txen && tx_pos == flip_pos) rxdat <= ~txdat;
			if (txen && tx_pos == 8 && frame_kind == KIND_BAD_MAC) begin
				rxdat <= LOCAL_MAC[47:40] ^ 8'h80;   // first dest mac byte
			end
			if (txen) begin
				// start seen at +1, txen registered at +2, sampled here at +3
				if (!prev_txen) begin
					assert (cyc == start_cyc + 3)
						else report_mismatch("o_gmii_txen rise cycle", cyc, start_cyc + 3);
				end
				if (tx_pos < 7) begin
					assert (txdat == 8'h55) else report_mismatch("o_gmii_txdat", txdat, 8'h55);
				end
				if (tx_pos == 7) begin
					assert (txdat == 8'hd5) else report_mismatch("o_gmii_txdat", txdat, 8'hd5);
				end
				if (tx_pos >= 8 && tx_pos < 50) begin
					assert (txdat == header_byte(cur_len, tx_pos - 8))
						else report_mismatch("o_gmii_txdat", txdat,
							header_byte(cur_len, tx_pos - 8));
				end
				if (tx_pos >= 50 + cur_len && tx_pos < 68) begin
					assert (txdat == 8'h00) else report_mismatch("o_gmii_txdat pad", txdat, 8'h00);
				end
				tx_pos <= tx_pos + 1;
			end else if (prev_txen) begin
				assert (tx_pos == wire_len(cur_len))
					else report_mismatch("o_gmii_txen burst length", tx_pos, wire_len(cur_len));
				burst_total <= burst_total + 1;
				tx_pos      <= 0;
			end
			assert (data_done == fell_last)
				else report_mismatch("o_tx_data_done", data_done, fell_last);
			if (data_done) begin
				assert (req_count == (cur_len + 3) / 4)
					else report_mismatch("o_tx_data_req pulses", req_count, (cur_len + 3) / 4);
				req_count     <= 0;
				tx_done_total <= tx_done_total + 1;
			end else if (data_req) begin
				req_count <= req_count + 1;
			end
			fell_last <= prev_txen && !txen;
			prev_txen <= txen;
		end
	end

	// ########################################
	// receive checks
	always @(posedge sys_clk) begin
		if (!reset_n) begin
			wr_total  <= 0;
			ok_total  <= 0;
			err_total <= 0;
		end else begin
			if (wr_en) begin
				assert (frame_kind != KIND_BAD_MAC)
					else report_failure("write strobe on a frame with a foreign mac");
				assert (wr_byte_num == cur_len)
					else report_mismatch("o_rxd_wr_byte_num", wr_byte_num, cur_len);
				if (frame_kind == KIND_CLEAN) begin
					assert (wr_data == expected_word(frame_base, wr_total - wr_base, cur_len))
						else report_mismatch("o_rxd_wr_data", wr_data,
							expected_word(frame_base, wr_total - wr_base, cur_len));
				end
				wr_total <= wr_total + 1;
			end
			if (pkt_done) begin
				assert (frame_kind == KIND_CLEAN)
					else report_failure("pkt_done on a corrupted or filtered frame");
				assert (wr_byte_num == cur_len)
					else report_mismatch("o_rxd_wr_byte_num", wr_byte_num, cur_len);
				ok_total <= ok_total + 1;
			end
			if (pkt_err) begin
				assert (frame_kind == KIND_FLIP)
					else report_failure("pkt_err on a frame with a good fcs or a foreign mac");
				err_total <= err_total + 1;
			end
		end
	end

	task automatic send_frame(input int f);
		int done_snap;
		int ok_snap;
		int err_snap;
		cur_len    = plan_len[f];
		frame_kind = plan_kind[f];
		flip_pos   = plan_flip[f];
		frame_base = word_ctr;
		wr_base    = wr_total;
		done_snap  = tx_done_total;
		ok_snap    = ok_total;
		err_snap   = err_total;
		@(posedge sys_clk);
		tx_start  <= 1'b1;
		tx_num    <= 16'(cur_len);
		start_cyc = cyc;
		@(posedge sys_clk);
		tx_start <= 1'b0;
		frames_started++;
		if (f == DOUBLE_FRAME) begin
			repeat (20) @(posedge sys_clk);   // inside the headers
			tx_start <= 1'b1;
			tx_num   <= 16'd50;
			@(posedge sys_clk);
			tx_start <= 1'b0;
		end
		while (tx_done_total == done_snap) @(posedge sys_clk);
		if (frame_kind != KIND_BAD_MAC) begin
			while (ok_total + err_total == ok_snap + err_snap) @(posedge sys_clk);
		end
		repeat (eth_ctrl_pkg::IFG_LEN) @(posedge sys_clk);
		assert (ok_total - ok_snap == ((frame_kind == KIND_CLEAN) ? 1 : 0))
			else report_mismatch("o_rxd_pkt_done pulses", ok_total - ok_snap, frame_kind == KIND_CLEAN);
		assert (err_total - err_snap == ((frame_kind == KIND_FLIP) ? 1 : 0))
			else report_mismatch("o_rxd_pkt_err pulses", err_total - err_snap, frame_kind == KIND_FLIP);
		assert (wr_total - wr_base == ((frame_kind == KIND_BAD_MAC) ? 0 : (cur_len + 3) / 4))
			else report_mismatch("o_rxd_wr_en pulses", wr_total - wr_base,
				(frame_kind == KIND_BAD_MAC) ? 0 : (cur_len + 3) / 4);
	endtask

	// ########################################
	// main sequence
	initial begin
		logic [31:0] r;
		int n_clean;
		int n_flip;
		reset_n        = 1'b0;
		tx_start       = 1'b0;
		tx_num         = '0;
		cur_len        = 0;
		frame_kind     = KIND_CLEAN;
		flip_pos       = -1;
		wr_base        = 0;
		start_cyc      = 0;
		frames_started = 0;
		frame_base     = '0;
		n_clean        = 0;
		n_flip         = 0;
		cyc_limit      = 16;   // reset and slack
		for (int f = 0; f < NUM_FRAMES; f++) begin
			draw_bits(7, r);
			plan_len[f] = 1 + int'(r) % 100;
			if (f < 2) plan_len[f] = 1 + int'(r) % 17;   // short, padded on the wire
			plan_kind[f] = (f == 6 || f == 7) ? KIND_FLIP : (f == 8) ? KIND_BAD_MAC : KIND_CLEAN;
			plan_flip[f] = -1;
			if (plan_kind[f] == KIND_CLEAN) n_clean++;
			if (plan_kind[f] == KIND_FLIP) n_flip++;
			cyc_limit += wire_len(plan_len[f]) + 2 * eth_ctrl_pkg::IFG_LEN + 8;
		end
		draw_bits(5, r);
		plan_flip[6] = 50 + int'(r) % plan_len[6];          // a payload byte
		draw_bits(2, r);
		plan_flip[7] = wire_len(plan_len[7]) - 4 + int'(r);  // an fcs byte
		draw_bits(32, r);
		word_seed = r;

		repeat (4) @(posedge sys_clk);
		reset_n <= 1'b1;
		for (int f = 0; f < NUM_FRAMES; f++) send_frame(f);

		// one burst and one done per start taken in idle
		if (burst_total != frames_started) begin
			report_mismatch("o_gmii_txen bursts", burst_total, frames_started);
		end else if (tx_done_total != frames_started) begin
			report_mismatch("o_tx_data_done pulses", tx_done_total, frames_started);
		end else if (ok_total != n_clean) begin
			report_mismatch("o_rxd_pkt_done pulses", ok_total, n_clean);
		end else if (err_total != n_flip) begin
			report_mismatch("o_rxd_pkt_err pulses", err_total, n_flip);
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
